/* src/fpu_fmt_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Double-precision word format
// Field widths, exponent bias and the special words that the unit returns
// Field struct and the word union shared by the datapath
////////////////////////////////////////////////////////////////////////////

package fpu_fmt_pkg;

	// Field widths of an IEEE 754 binary64 word
	localparam int EXP_W = 11;
	localparam int MAN_W = 52;
	localparam int WORD_W = 64;

	localparam int EXP_BIAS = 1023;

	// Exponent of infinity and NaN
	localparam logic [EXP_W-1:0] EXP_MAX = '1;

	// Default quiet NaN, returned for the square root of a negative number
	localparam logic [WORD_W-1:0] QNAN_WORD = 64'h7FF8_0000_0000_0000;

	// Pattern returned for an op or mode the unit does not implement
	localparam logic [WORD_W-1:0] ILLEGAL_WORD = 64'h0000_0000_DEAD_BEEF;

	// Seed table is indexed by the exponent parity and the top mantissa bits
	localparam int SEED_IDX_W = 9;
	localparam int SEED_MAN_W = 8;

	typedef struct packed {
		logic sign;
		logic [EXP_W-1:0] exp;
		logic [MAN_W-1:0] man;
	} fp64_fields_t;

	// Raw view travels on the ports, the fields view is used for decoding
	typedef union packed {
		logic [WORD_W-1:0] raw;
		fp64_fields_t fields;
	} fp64_word_u;

endpackage

/* src/fpu_op_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Operation encoding of the auxiliary unit
// Op codes, sign-injection sub-modes and per-op latencies
// Request struct captured by the sequencer
////////////////////////////////////////////////////////////////////////////

package fpu_op_pkg;

	localparam int OP_W = 5;
	localparam logic [OP_W-1:0] OP_SQRT_SEED = 5'd11;
	localparam logic [OP_W-1:0] OP_SGNJ = 5'd23;

	// Sign injection takes its sub-mode from the rounding-mode input
	localparam int MODE_W = 3;
	// Modes 000 and 001 copy the sign of opb, so only bit 0 is free
	localparam logic [MODE_W-1:0] SGNJ_COPY_MASK = 3'b110;
	localparam logic [MODE_W-1:0] SGNJ_MOVE = 3'b011;

	// Cycles from the start edge to the rise of ready
	localparam int LAT_SQRT_SEED = 24;
	localparam int LAT_SGNJ = 10;
	localparam int LAT_OTHER = 10;

	localparam int CNT_W = 7;

	typedef struct packed {
		logic [OP_W-1:0] op;
		logic [MODE_W-1:0] mode;
		logic [fpu_fmt_pkg::WORD_W-1:0] opa;
		logic [fpu_fmt_pkg::WORD_W-1:0] opb;
	} fpu_req_t;

endpackage

/* src/fpu_seq_ctrl.sv */
////////////////////////////////////////////////////////////////////////////
// Start and cycle-count sequencer
// Detects a rising enable, captures the request and counts the op latency
// Drives the capture and done pulses and the ready level
////////////////////////////////////////////////////////////////////////////

module fpu_seq_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic enable,
	input  logic [fpu_op_pkg::OP_W-1:0] fpu_op,
	input  logic [fpu_op_pkg::MODE_W-1:0] rnd_mode,
	input  logic [fpu_fmt_pkg::WORD_W-1:0] opa,
	input  logic [fpu_fmt_pkg::WORD_W-1:0] opb,
	output logic capture,
	output fpu_op_pkg::fpu_req_t req,
	output logic done,
	output logic ready
);
	import fpu_op_pkg::*;

	logic enable_prev;
	logic start;
	logic busy;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_load;

	// A start is enable seen high after it was seen low at the previous edge
	assign start = enable && !enable_prev;

	// The counter runs out one edge before ready, so it starts at L-2
	always_comb
	begin
		case (fpu_op)
			OP_SQRT_SEED: cnt_load = CNT_W'(LAT_SQRT_SEED - 2);
			OP_SGNJ: cnt_load = CNT_W'(LAT_SGNJ - 2);
			default: cnt_load = CNT_W'(LAT_OTHER - 2);
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (start)
			req <= '{op: fpu_op, mode: rnd_mode, opa: opa, opb: opb};
	end

	//////////////////////////////////////////////////////////////////////////
	// Control state
	//////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			enable_prev <= 1'b0;
			capture <= 1'b0;
			busy <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
			ready <= 1'b0;
		end
		else
		begin
			enable_prev <= enable;
			capture <= start;
			if (start)
			begin
				// A new start also aborts a run in flight
				busy <= 1'b1;
				cnt <= cnt_load;
				done <= 1'b0;
				ready <= 1'b0;
			end
			else
			begin
				done <= 1'b0;
				if (busy)
				begin
					if (cnt == '0)
					begin
						busy <= 1'b0;
						done <= 1'b1;
					end
					else
						cnt <= cnt - 1'b1;
				end
				// Ready follows done so it rises with the registered result
				if (done)
					ready <= 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) !(ready && busy));
	assert property (@(posedge clk) disable iff (rst) capture |-> !done);

endmodule

/* src/sqrt_seed_unit.sv */
////////////////////////////////////////////////////////////////////////////
// Square-root seed estimate
// Seed table built by a constant function from an integer square root
// Registered seed of the captured operand, with NaN handling
////////////////////////////////////////////////////////////////////////////

module sqrt_seed_unit (
	input  logic clk,
	input  logic rst,
	input  logic capture,
	input  fpu_op_pkg::fpu_req_t req,
	output logic [fpu_fmt_pkg::WORD_W-1:0] seed,
	output logic seed_invalid
);
	import fpu_fmt_pkg::*;

	localparam int SEED_DEPTH = 2 ** SEED_IDX_W;
	localparam int EXP_SUM_W = EXP_W + 1;

	typedef logic [SEED_DEPTH-1:0][SEED_MAN_W-1:0] seed_table_t;

	// Entry i is floor(256 * (sqrt(x) - 1)) with x = (1 + m/256) * (1 + e0)
	function automatic seed_table_t build_seed_table();
		seed_table_t tab;
		int unsigned base;
		int unsigned x;
		int unsigned r;
		int unsigned t;
		base = 1 << SEED_MAN_W;
		for (int i = 0; i < SEED_DEPTH; i++)
		begin
			x = (base + (i % base)) * (1 + i / base) * base;
			// Bitwise integer square root, the root is below 2*base
			r = 0;
			for (int b = SEED_MAN_W + 1; b >= 0; b--)
			begin
				t = r | (1 << b);
				if (t * t <= x)
					r = t;
			end
			tab[i] = SEED_MAN_W'(r - base);
		end
		return tab;
	endfunction

	localparam seed_table_t SEED_TABLE = build_seed_table();

	fp64_word_u opa_w;
	fp64_word_u seed_d;
	fp64_word_u seed_q;
	logic opa_zero;
	logic opa_neg;
	logic opa_special;
	logic [SEED_IDX_W-1:0] seed_idx;
	logic [EXP_SUM_W-1:0] exp_sum;

	assign opa_w = req.opa;
	assign opa_zero = (opa_w.fields.exp == '0) && (opa_w.fields.man == '0);
	assign opa_neg = opa_w.fields.sign && !opa_zero;
	assign opa_special = (opa_w.fields.exp == '0) || (opa_w.fields.exp == EXP_MAX);

	// An odd biased exponent is an even power of two, so its mantissa is in [1,2)
	assign seed_idx = {~opa_w.fields.exp[0], opa_w.fields.man[MAN_W-1 -: SEED_MAN_W]};
	assign exp_sum = {1'b0, opa_w.fields.exp} + EXP_SUM_W'(EXP_BIAS);

	always_comb
	begin
		seed_d = opa_w;
		if (opa_neg)
			seed_d.raw = QNAN_WORD;
		else if (!opa_special)
		begin
			seed_d.fields.sign = 1'b0;
			seed_d.fields.exp = exp_sum[EXP_SUM_W-1:1];
			seed_d.fields.man = {SEED_TABLE[seed_idx], {(MAN_W - SEED_MAN_W){1'b0}}};
		end
	end

	always_ff @(posedge clk)
	begin
		if (capture)
			seed_q <= seed_d;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			seed_invalid <= 1'b0;
		else if (capture)
			seed_invalid <= opa_neg;
	end

	assign seed = seed_q.raw;

	// A normal operand never yields a zero or all-ones seed exponent
	assert property (@(posedge clk) disable iff (rst)
		capture && !opa_neg && !opa_special
		|=> (seed_q.fields.exp != '0) && (seed_q.fields.exp != EXP_MAX));

endmodule

/* src/fpu_result_stage.sv */
////////////////////////////////////////////////////////////////////////////
// Result stage
// Sign injection on the captured operands
// Result select by op and mode, registered out and invalid on done
////////////////////////////////////////////////////////////////////////////

module fpu_result_stage (
	input  logic clk,
	input  logic rst,
	input  fpu_op_pkg::fpu_req_t req,
	input  logic [fpu_fmt_pkg::WORD_W-1:0] seed,
	input  logic seed_invalid,
	input  logic done,
	output logic [fpu_fmt_pkg::WORD_W-1:0] out,
	output logic invalid
);
	import fpu_fmt_pkg::*;
	import fpu_op_pkg::*;

	fp64_word_u opa_w;
	fp64_word_u opb_w;
	fp64_word_u sgnj_w;
	fp64_word_u res_d;
	logic invalid_d;

	assign opa_w = req.opa;
	assign opb_w = req.opb;

	// Magnitude of opa with the sign of opb
	always_comb
	begin
		sgnj_w = opa_w;
		sgnj_w.fields.sign = opb_w.fields.sign;
	end

	//////////////////////////////////////////////////////////////////////////
	// Result select
	//////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Anything not decoded below is an illegal op or mode
		res_d.raw = ILLEGAL_WORD;
		invalid_d = 1'b1;
		case (req.op)
			OP_SQRT_SEED:
			begin
				res_d.raw = seed;
				invalid_d = seed_invalid;
			end
			OP_SGNJ:
			begin
				if ((req.mode & SGNJ_COPY_MASK) == '0)
				begin
					res_d = sgnj_w;
					invalid_d = 1'b0;
				end
				else if (req.mode == SGNJ_MOVE)
				begin
					res_d = opa_w;
					invalid_d = 1'b0;
				end
			end
			default:
			begin
				res_d.raw = ILLEGAL_WORD;
				invalid_d = 1'b1;
			end
		endcase
	end

	// Result holds until the next done overwrites it
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out <= '0;
			invalid <= 1'b0;
		end
		else if (done)
		begin
			out <= res_d.raw;
			invalid <= invalid_d;
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		invalid |-> (out == QNAN_WORD) || (out == ILLEGAL_WORD));

endmodule

/* src/fpu_aux_unit.sv */
////////////////////////////////////////////////////////////////////////////
// Auxiliary double-precision unit, top level
// Sequencer feeding the square-root seed unit and the result stage
////////////////////////////////////////////////////////////////////////////

module fpu_aux_unit (
	input  logic clk,
	input  logic rst,
	input  logic enable,
	input  logic [fpu_op_pkg::OP_W-1:0] fpu_op,
	input  logic [fpu_op_pkg::MODE_W-1:0] rnd_mode,
	input  logic [fpu_fmt_pkg::WORD_W-1:0] opa,
	input  logic [fpu_fmt_pkg::WORD_W-1:0] opb,
	output logic [fpu_fmt_pkg::WORD_W-1:0] out,
	output logic invalid,
	output logic ready
);
	import fpu_fmt_pkg::*;
	import fpu_op_pkg::*;

	logic capture;
	logic done;
	fpu_req_t req;
	logic [WORD_W-1:0] seed;
	logic seed_invalid;

	fpu_seq_ctrl fpu_seq_ctrl_inst (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.fpu_op(fpu_op),
		.rnd_mode(rnd_mode),
		.opa(opa),
		.opb(opb),
		.capture(capture),
		.req(req),
		.done(done),
		.ready(ready)
	);

	sqrt_seed_unit sqrt_seed_unit_inst (
		.clk(clk),
		.rst(rst),
		.capture(capture),
		.req(req),
		.seed(seed),
		.seed_invalid(seed_invalid)
	);

	fpu_result_stage fpu_result_stage_inst (
		.clk(clk),
		.rst(rst),
		.req(req),
		.seed(seed),
		.seed_invalid(seed_invalid),
		.done(done),
		.out(out),
		.invalid(invalid)
	);

endmodule

/* test/fpu_aux_checker.sv */
////////////////////////////////////////////////////////////////////////////
// Checker for the auxiliary double-precision unit
// Reference model of the start rule, latencies, seed and sign injection
// Compares out, invalid and the ready edge against the model every cycle
////////////////////////////////////////////////////////////////////////////

module fpu_aux_checker (
	input  logic clk,
	input  logic rst,
	input  logic enable,
	input  logic [fpu_op_pkg::OP_W-1:0] fpu_op,
	input  logic [fpu_op_pkg::MODE_W-1:0] rnd_mode,
	input  logic [fpu_fmt_pkg::WORD_W-1:0] opa,
	input  logic [fpu_fmt_pkg::WORD_W-1:0] opb,
	input  logic [fpu_fmt_pkg::WORD_W-1:0] out,
	input  logic invalid,
	input  logic ready,
	output int value_errors,
	output int timing_errors,
	output int results_seen
);
	timeunit 1ns;
	timeprecision 1ps;
	import fpu_fmt_pkg::*;
	import fpu_op_pkg::*;

	int cyc;
	int due;
	int start_edge;
	int cur_lat;
	logic armed;
	logic en_prev;
	logic pend;
	logic fresh;
	logic model_ready;
	logic model_valid;
	logic model_inv;
	logic [WORD_W-1:0] model_out;
	logic [WORD_W:0] pend_res;

	// floor(256 * (sqrt(x) - 1)) with x = (1 + m/256) * (1 + e0), by a plain root search
	function automatic logic [SEED_MAN_W-1:0] table_entry(input logic [SEED_IDX_W-1:0] idx);
		int unsigned x;
		int unsigned r;
		x = (256 + int'(idx[7:0])) * (1 + int'(idx[8])) * 256;
		r = 0;
		while ((r + 1) * (r + 1) <= x)
			r++;
		return SEED_MAN_W'(r - 256);
	endfunction

	function automatic int latency_of(input logic [OP_W-1:0] op);
		if (op == OP_SQRT_SEED)
			return LAT_SQRT_SEED;
		else if (op == OP_SGNJ)
			return LAT_SGNJ;
		return LAT_OTHER;
	endfunction

	// Returns invalid on top of the 64-bit result word
	function automatic logic [WORD_W:0] expected_result(
		input logic [OP_W-1:0] op,
		input logic [MODE_W-1:0] mode,
		input logic [WORD_W-1:0] a,
		input logic [WORD_W-1:0] b
	);
		fp64_word_u w;
		fp64_word_u r;
		logic inv;
		logic zero;
		w.raw = a;
		r.raw = ILLEGAL_WORD;
		inv = 1'b1;
		zero = (w.fields.exp == '0) && (w.fields.man == '0);
		if (op == OP_SQRT_SEED)
		begin
			inv = 1'b0;
			if (w.fields.sign && !zero)
			begin
				r.raw = QNAN_WORD;
				inv = 1'b1;
			end
			else if ((w.fields.exp == '0) || (w.fields.exp == EXP_MAX))
				r.raw = a;
			else
			begin
				r.fields.sign = 1'b0;
				r.fields.exp = EXP_W'((int'(w.fields.exp) + EXP_BIAS) / 2);
				r.fields.man = {table_entry({~w.fields.exp[0], w.fields.man[51:44]}), 44'd0};
			end
		end
		else if ((op == OP_SGNJ) && ((mode == 3'b000) || (mode == 3'b001)))
		begin
			r.raw = {b[63], a[62:0]};
			inv = 1'b0;
		end
		else if ((op == OP_SGNJ) && (mode == 3'b011))
		begin
			r.raw = a;
			inv = 1'b0;
		end
		return {inv, r.raw};
	endfunction

	initial
	begin
		value_errors = 0;
		timing_errors = 0;
		results_seen = 0;
		cyc = 0;
		armed = 1'b0;
	end

	//////////////////////////////////////////////////////////////////////////
	// Compare the state after the previous edge, then advance the model
	//////////////////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		cyc++;
		if (armed)
		begin
			if (ready !== model_ready)
			begin
				timing_errors++;
				if (model_ready)
					$display("Error at %0d ns: ready did not rise %0d cycles after the start at edge %0d",
						$time, cur_lat, start_edge);
				else
					$display("[FAIL] %0d ns: ready is %b, expected 0", $time, ready);
			end
			if (model_valid && (out !== model_out))
			begin
				value_errors++;
				$display("[FAIL] %0d ns: out is %h, expected %h", $time, out, model_out);
			end
			if (model_valid && (invalid !== model_inv))
			begin
				value_errors++;
				$display("[FAIL] %0d ns: invalid is %b, expected %b", $time, invalid, model_inv);
			end
			if (model_valid && fresh)
			begin
				results_seen++;
				fresh = 1'b0;
			end
		end
		if (rst)
		begin
			armed = 1'b1;
			en_prev = 1'b0;
			pend = 1'b0;
			fresh = 1'b0;
			model_ready = 1'b0;
			model_valid = 1'b1;
			model_out = '0;
			model_inv = 1'b0;
		end
		else if (armed)
		begin
			if (pend && (cyc == due))
			begin
				pend = 1'b0;
				fresh = 1'b1;
				model_ready = 1'b1;
				model_valid = 1'b1;
				model_out = pend_res[WORD_W-1:0];
				model_inv = pend_res[WORD_W];
			end
			// A new start discards whatever was running or just finished
			if (enable && !en_prev)
			begin
				pend_res = expected_result(fpu_op, rnd_mode, opa, opb);
				cur_lat = latency_of(fpu_op);
				start_edge = cyc;
				due = cyc + cur_lat;
				pend = 1'b1;
				fresh = 1'b0;
				model_ready = 1'b0;
				model_valid = 1'b0;
			end
			en_prev = enable;
		end
	end

endmodule

/* test/tb_fpu_aux_unit.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the auxiliary double-precision unit
// Clock, reset, seeded random ops, restarts and a watchdog
// Instantiates the DUT and the checker and prints the result
////////////////////////////////////////////////////////////////////////////

module tb_fpu_aux_unit;
	timeunit 1ns;
	timeprecision 1ps;
	import fpu_fmt_pkg::*;
	import fpu_op_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 4;
	localparam int N_SQRT = 40;
	localparam int N_SPECIAL = 16;
	localparam int N_SGNJ = 24;
	localparam int N_ILLEGAL = 10;
	localparam int N_RESTART = 8;
	// A restart and the held enable each take the time of two ops
	localparam int NUM_OPS = N_SQRT + N_SPECIAL + N_SGNJ + N_ILLEGAL + 2 * N_RESTART + 2;
	localparam int NUM_RESULTS = N_SQRT + N_SPECIAL + N_SGNJ + N_ILLEGAL + N_RESTART + 1;
	localparam int WATCHDOG_CYCLES = NUM_OPS * (LAT_SQRT_SEED + 10) + RESET_CYCLES + 32;
	localparam int WAIT_LIMIT = LAT_SQRT_SEED + 8;

	logic clk;
	logic rst;
	logic enable;
	logic [OP_W-1:0] fpu_op;
	logic [MODE_W-1:0] rnd_mode;
	logic [WORD_W-1:0] opa;
	logic [WORD_W-1:0] opb;
	logic [WORD_W-1:0] out;
	logic invalid;
	logic ready;
	int value_errors;
	int timing_errors;
	int results_seen;
	int stall_errors;

	fpu_aux_unit fpu_aux_unit_inst (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.fpu_op(fpu_op),
		.rnd_mode(rnd_mode),
		.opa(opa),
		.opb(opb),
		.out(out),
		.invalid(invalid),
		.ready(ready)
	);

	fpu_aux_checker fpu_aux_checker_inst (
		.clk(clk),
		.rst(rst),
		.enable(enable),
		.fpu_op(fpu_op),
		.rnd_mode(rnd_mode),
		.opa(opa),
		.opb(opb),
		.out(out),
		.invalid(invalid),
		.ready(ready),
		.value_errors(value_errors),
		.timing_errors(timing_errors),
		.results_seen(results_seen)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [WORD_W-1:0] rand_word();
		return {$urandom, $urandom};
	endfunction

	function automatic logic [WORD_W-1:0] positive_normal();
		fp64_word_u w;
		w.raw = rand_word();
		w.fields.sign = 1'b0;
		w.fields.exp = EXP_W'($urandom_range(1, 2046));
		return w.raw;
	endfunction

	// Negative, zero, infinite, NaN and denormal operands by kind
	function automatic logic [WORD_W-1:0] special_operand(input int kind);
		fp64_word_u w;
		w.raw = rand_word();
		case (kind)
			0:
			begin
				w.fields.sign = 1'b1;
				w.fields.exp = EXP_W'($urandom_range(1, 2046));
			end
			1: w.raw = '0;
			2: w.raw = {1'b1, 63'd0};
			3: w.raw = {1'b0, EXP_MAX, 52'd0};
			4:
			begin
				w.fields.sign = 1'b0;
				w.fields.exp = EXP_MAX;
				w.fields.man[51] = 1'b1;
			end
			5: w.raw = {1'b1, EXP_MAX, 52'd0};
			6:
			begin
				w.fields.sign = 1'b0;
				w.fields.exp = '0;
			end
			default:
			begin
				w.fields.sign = 1'b1;
				w.fields.exp = '0;
				w.fields.man[0] = 1'b1;
			end
		endcase
		return w.raw;
	endfunction

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// Raises enable for hold edges, then scrambles the inputs behind the capture
	task automatic start_op(input logic [OP_W-1:0] op, input logic [MODE_W-1:0] mode,
		input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b, input int hold);
		fpu_op = op;
		rnd_mode = mode;
		opa = a;
		opb = b;
		enable = 1'b1;
		idle_cycles(hold);
		enable = 1'b0;
		fpu_op = OP_W'($urandom);
		rnd_mode = MODE_W'($urandom);
		opa = rand_word();
		opb = rand_word();
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		while (!ready && (n < WAIT_LIMIT))
		begin
			idle_cycles(1);
			n++;
		end
		if (!ready)
		begin
			stall_errors++;
			$display("Error at %0d ns: ready did not rise within %0d cycles", $time, WAIT_LIMIT);
		end
		idle_cycles(3);
	endtask

	task automatic run_op(input logic [OP_W-1:0] op, input logic [MODE_W-1:0] mode,
		input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b, input int hold);
		start_op(op, mode, a, b, hold);
		wait_ready();
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES)
			@(posedge clk);
		$display("Watchdog expired at %0d ns before the tests finished", $time);
		$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		logic [OP_W-1:0] op;
		logic [MODE_W-1:0] mode;
		void'($urandom(2625));
		stall_errors = 0;
		rst = 1'b1;
		enable = 1'b0;
		fpu_op = '0;
		rnd_mode = '0;
		opa = '0;
		opb = '0;
		idle_cycles(RESET_CYCLES);
		rst = 1'b0;
		// Outputs must stay at zero while nothing has started
		idle_cycles(8);
		for (int i = 0; i < N_SQRT; i++)
			run_op(OP_SQRT_SEED, MODE_W'($urandom), positive_normal(), rand_word(),
				$urandom_range(1, 3));
		for (int i = 0; i < N_SPECIAL; i++)
			run_op(OP_SQRT_SEED, 3'b000, special_operand(i % 8), rand_word(), 1);
		for (int i = 0; i < N_SGNJ; i++)
		begin
			mode = MODE_W'($urandom_range(0, 2));
			if (mode == 3'd2)
				mode = SGNJ_MOVE;
			run_op(OP_SGNJ, mode, rand_word(), rand_word(), $urandom_range(1, 3));
		end
		for (int i = 0; i < N_ILLEGAL; i++)
		begin
			op = OP_SGNJ;
			do
				mode = MODE_W'($urandom);
			while ((mode == 3'b000) || (mode == 3'b001) || (mode == SGNJ_MOVE));
			if (i % 2 == 1)
			begin
				do
					op = OP_W'($urandom);
				while ((op == OP_SQRT_SEED) || (op == OP_SGNJ));
			end
			run_op(op, mode, rand_word(), rand_word(), 1);
		end
		// A second rising enable before ready replaces the running op
		for (int i = 0; i < N_RESTART; i++)
		begin
			op = ($urandom_range(0, 1) == 1) ? OP_SQRT_SEED : OP_SGNJ;
			start_op(op, 3'b000, positive_normal(), rand_word(), 1);
			idle_cycles($urandom_range(1, 8));
			op = ($urandom_range(0, 1) == 1) ? OP_SQRT_SEED : OP_SGNJ;
			run_op(op, 3'b001, positive_normal(), rand_word(), 1);
		end
		run_op(OP_SGNJ, 3'b000, rand_word(), rand_word(), 30);
		if (results_seen != NUM_RESULTS)
			$display("Error: %0d results were checked, %0d were expected", results_seen,
				NUM_RESULTS);
		$display("Errors: %0d value, %0d timing, %0d stalled, %0d of %0d results checked",
			value_errors, timing_errors, stall_errors, results_seen, NUM_RESULTS);
		if ((value_errors == 0) && (timing_errors == 0) && (stall_errors == 0)
			&& (results_seen == NUM_RESULTS))
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* all.f */
src/fpu_fmt_pkg.sv
src/fpu_op_pkg.sv
src/fpu_seq_ctrl.sv
src/sqrt_seed_unit.sv
src/fpu_result_stage.sv
src/fpu_aux_unit.sv
test/fpu_aux_checker.sv
test/tb_fpu_aux_unit.sv

/* Bender.yml */
package:
  name: fpu_aux_unit

sources:
  - src/fpu_fmt_pkg.sv
  - src/fpu_op_pkg.sv
  - src/fpu_seq_ctrl.sv
  - src/sqrt_seed_unit.sv
  - src/fpu_result_stage.sv
  - src/fpu_aux_unit.sv
  - target: test
    files:
      - test/fpu_aux_checker.sv
      - test/tb_fpu_aux_unit.sv
